/* hw/memCtrl_cfg.svh */
`ifndef MEM_CTRL_CFG_SVH
`define MEM_CTRL_CFG_SVH

// byte address width of the shared RAM
`define MEM_ADDR_W 16

// RAM size in bytes
`define MEM_DEPTH (1 << `MEM_ADDR_W)

`endif

/* hw/memCtrlPkg.sv */
package memCtrlPkg;

    // what an access does on the byte RAM
    typedef enum logic [1:0] {
        kindFetch = 2'd0,
        kindLoad  = 2'd1,
        kindStore = 2'd2
    } accessKind;

    // which port asked, and so which port gets the response
    typedef enum logic {
        fetchPort = 1'b0,
        dataPort  = 1'b1
    } reqSource;

    // access length of 1, 2 or 4 bytes
    typedef logic [2:0] accessLen;

    typedef logic [31:0] memWord;

    // legal lengths
    localparam accessLen lenByte = 3'd1;
    localparam accessLen lenHalf = 3'd2;
    localparam accessLen lenWord = 3'd4;

endpackage

/* hw/memReqIf.sv */
`timescale 1ns/100ps
`include "memCtrl_cfg.svh"

// one arbitrated request with a valid/ready handshake
interface memReqIf;
    logic                   valid;
    logic                   ready;
    memCtrlPkg::accessKind  kind;
    memCtrlPkg::reqSource   source;
    logic [`MEM_ADDR_W-1:0] addr;
    memCtrlPkg::accessLen   len;
    memCtrlPkg::memWord     wdata;

    modport master (
        output valid, kind, source, addr, len, wdata,
        input  ready
    );

    modport slave (
        input  valid, kind, source, addr, len, wdata,
        output ready
    );
endinterface

/* hw/memRespIf.sv */
`timescale 1ns/100ps

// completed access with a single-cycle valid pulse
interface memRespIf;
    logic                  valid;
    memCtrlPkg::reqSource  source;
    memCtrlPkg::accessKind kind;
    memCtrlPkg::accessLen  len;
    memCtrlPkg::memWord    data;

    modport master (
        output valid, source, kind, len, data
    );

    modport slave (
        input valid, source, kind, len, data
    );
endinterface

/* hw/memArbiter.sv */
`timescale 1ns/100ps
`include "memCtrl_cfg.svh"

module memArbiter (
    input  logic                   clk,
    input  logic                   rst,

    input  logic                   fetchValid,
    output logic                   fetchReady,
    input  logic [`MEM_ADDR_W-1:0] fetchAddr,

    input  logic                   dataValid,
    output logic                   dataReady,
    input  logic                   dataWrite,
    input  memCtrlPkg::accessLen   dataLen,
    input  logic [`MEM_ADDR_W-1:0] dataAddr,
    input  memCtrlPkg::memWord     dataWdata,

    memReqIf.master                req
);
    logic stageValid;
    logic stageFree;
    logic takeData;
    logic takeFetch;

    // stage can refill in the cycle it hands off
    assign stageFree = !stageValid || req.ready;

    // data port first and fetch waits while data is asking
    assign dataReady  = stageFree;
    assign fetchReady = stageFree && !dataValid;

    assign takeData  = dataValid && dataReady;
    assign takeFetch = fetchValid && fetchReady;

    assign req.valid = stageValid;

    always_ff @(posedge clk) begin
        if (rst) begin
            stageValid <= 1'b0;
        end else if (takeData || takeFetch) begin
            stageValid <= 1'b1;
        end else if (req.ready) begin
            stageValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (takeData) begin
            req.kind   <= dataWrite ? memCtrlPkg::kindStore : memCtrlPkg::kindLoad;
            req.source <= memCtrlPkg::dataPort;
            req.addr   <= dataAddr;
            req.len    <= dataLen;
            req.wdata  <= dataWdata;
        end else if (takeFetch) begin
            // instruction fetch is always a whole word
            req.kind   <= memCtrlPkg::kindFetch;
            req.source <= memCtrlPkg::fetchPort;
            req.addr   <= fetchAddr;
            req.len    <= memCtrlPkg::lenWord;
            req.wdata  <= '0;
        end
    end

endmodule

/* hw/byteSequencer.sv */
`timescale 1ns/100ps
`include "memCtrl_cfg.svh"

module byteSequencer (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   ioFull,

    memReqIf.slave                 req,
    memRespIf.master               resp,

    output logic                   ramWe,
    output logic [`MEM_ADDR_W-1:0] ramAddr,
    output logic [7:0]             ramWdata,
    input  logic [7:0]             ramRdata
);
    logic                   busy;
    logic                   accept;
    logic                   issue;
    logic                   isLast;
    logic [2:0]             cnt;
    logic [2:0]             curIdx;
    logic [`MEM_ADDR_W-1:0] baseAddr;
    logic [`MEM_ADDR_W-1:0] lastAddr;
    logic [`MEM_ADDR_W-1:0] curAddr;
    memCtrlPkg::accessKind  kindReg;
    memCtrlPkg::accessKind  curKind;
    memCtrlPkg::reqSource   srcReg;
    memCtrlPkg::reqSource   curSrc;
    memCtrlPkg::accessLen   lenReg;
    memCtrlPkg::accessLen   curLen;
    memCtrlPkg::memWord     wdataReg;
    memCtrlPkg::memWord     curWdata;
    memCtrlPkg::memWord     asmWord;
    memCtrlPkg::memWord     capWord;
    logic                   rdPend;
    logic                   rdLast;
    logic [1:0]             rdLane;

    // idle means no bytes left to walk and no read byte still on its way back
    assign req.ready = !busy && !rdPend && !ioFull;
    assign accept    = req.valid && req.ready;

    // first byte goes out in the acceptance cycle
    assign issue = busy ? !ioFull : accept;

    always_comb begin
        if (busy) begin
            curKind  = kindReg;
            curSrc   = srcReg;
            curLen   = lenReg;
            curIdx   = cnt;
            curAddr  = baseAddr + {{(`MEM_ADDR_W - 3){1'b0}}, cnt};
            curWdata = wdataReg;
        end else begin
            curKind  = req.kind;
            curSrc   = req.source;
            curLen   = req.len;
            curIdx   = 3'd0;
            curAddr  = req.addr;
            curWdata = req.wdata;
        end
    end

    assign isLast = (curIdx + 3'd1) == curLen;

    // hold the last address while idle or stalled so rdata stays put
    assign ramWe    = issue && (curKind == memCtrlPkg::kindStore);
    assign ramAddr  = issue ? curAddr : lastAddr;
    assign ramWdata = curWdata[{curIdx[1:0], 3'b000} +: 8];

    // returning byte dropped into its own lane
    always_comb begin
        capWord = asmWord;
        capWord[{rdLane, 3'b000} +: 8] = ramRdata;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy       <= 1'b0;
            cnt        <= 3'd0;
            rdPend     <= 1'b0;
            rdLast     <= 1'b0;
            lastAddr   <= '0;
            resp.valid <= 1'b0;
        end else begin
            resp.valid <= 1'b0;
            if (!ioFull) begin
                if (issue) begin
                    busy     <= !isLast;
                    cnt      <= curIdx + 3'd1;
                    lastAddr <= curAddr;
                end
                rdPend <= issue && (curKind != memCtrlPkg::kindStore);
                rdLast <= isLast;
                // store is done once its last byte is written
                if (ramWe && isLast) begin
                    resp.valid <= 1'b1;
                end
                // reads finish a cycle later, when the last byte comes back
                if (rdPend && rdLast) begin
                    resp.valid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            kindReg  <= req.kind;
            srcReg   <= req.source;
            lenReg   <= req.len;
            baseAddr <= req.addr;
            wdataReg <= req.wdata;
            asmWord  <= '0;
        end else if (!ioFull && rdPend) begin
            asmWord <= capWord;
        end
        if (issue) begin
            rdLane <= curIdx[1:0];
        end
        if (ramWe && isLast) begin
            resp.source <= curSrc;
            resp.kind   <= curKind;
            resp.len    <= curLen;
            resp.data   <= '0;
        end else if (!ioFull && rdPend && rdLast) begin
            resp.source <= srcReg;
            resp.kind   <= kindReg;
            resp.len    <= lenReg;
            resp.data   <= capWord;
        end
    end

endmodule

/* hw/respRouter.sv */
`timescale 1ns/100ps

module respRouter (
    input  logic               clk,
    input  logic               rst,

    memRespIf.slave            resp,

    output logic               fetchRespValid,
    output memCtrlPkg::memWord fetchRespInst,

    output logic               dataRespValid,
    output memCtrlPkg::memWord dataRespData
);
    memCtrlPkg::memWord loadMask;

    // zero extension by access length
    always_comb begin
        case (resp.len)
            memCtrlPkg::lenByte: loadMask = 32'h0000_00ff;
            memCtrlPkg::lenHalf: loadMask = 32'h0000_ffff;
            default:             loadMask = 32'hffff_ffff;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fetchRespValid <= 1'b0;
            dataRespValid  <= 1'b0;
        end else begin
            fetchRespValid <= resp.valid && (resp.source == memCtrlPkg::fetchPort);
            dataRespValid  <= resp.valid && (resp.source == memCtrlPkg::dataPort);
        end
    end

    always_ff @(posedge clk) begin
        if (resp.valid) begin
            if (resp.source == memCtrlPkg::fetchPort) begin
                fetchRespInst <= resp.data;
            end else if (resp.kind == memCtrlPkg::kindStore) begin
                // stores only acknowledge
                dataRespData <= '0;
            end else begin
                dataRespData <= resp.data & loadMask;
            end
        end
    end

endmodule

/* hw/byteRam.sv */
`timescale 1ns/100ps
`include "memCtrl_cfg.svh"

module byteRam (
    input  logic                   clk,
    input  logic                   we,
    input  logic [`MEM_ADDR_W-1:0] addr,
    input  logic [7:0]             wdata,
    output logic [7:0]             rdata
);
    // power-up contents are all zero
    logic [7:0] mem [`MEM_DEPTH] = '{default: 8'h00};

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

    // registered read returns old data on a same-cycle write
    always_ff @(posedge clk) begin
        rdata <= mem[addr];
    end

endmodule

/* hw/memCtrlTop.sv */
`timescale 1ns/100ps
`include "memCtrl_cfg.svh"

module memCtrlTop (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   ioFull,

    input  logic                   fetchValid,
    output logic                   fetchReady,
    input  logic [`MEM_ADDR_W-1:0] fetchAddr,
    output logic                   fetchRespValid,
    output memCtrlPkg::memWord     fetchRespInst,

    input  logic                   dataValid,
    output logic                   dataReady,
    input  logic                   dataWrite,
    input  memCtrlPkg::accessLen   dataLen,
    input  logic [`MEM_ADDR_W-1:0] dataAddr,
    input  memCtrlPkg::memWord     dataWdata,
    output logic                   dataRespValid,
    output memCtrlPkg::memWord     dataRespData
);
    logic                   ramWe;
    logic [`MEM_ADDR_W-1:0] ramAddr;
    logic [7:0]             ramWdata;
    logic [7:0]             ramRdata;

    memReqIf  reqBus ();
    memRespIf respBus ();

    memArbiter i_memArbiter (
        .clk        (clk),
        .rst        (rst),
        .fetchValid (fetchValid),
        .fetchReady (fetchReady),
        .fetchAddr  (fetchAddr),
        .dataValid  (dataValid),
        .dataReady  (dataReady),
        .dataWrite  (dataWrite),
        .dataLen    (dataLen),
        .dataAddr   (dataAddr),
        .dataWdata  (dataWdata),
        .req        (reqBus.master)
    );

    byteSequencer i_byteSequencer (
        .clk      (clk),
        .rst      (rst),
        .ioFull   (ioFull),
        .req      (reqBus.slave),
        .resp     (respBus.master),
        .ramWe    (ramWe),
        .ramAddr  (ramAddr),
        .ramWdata (ramWdata),
        .ramRdata (ramRdata)
    );

    byteRam i_byteRam (
        .clk   (clk),
        .we    (ramWe),
        .addr  (ramAddr),
        .wdata (ramWdata),
        .rdata (ramRdata)
    );

    respRouter i_respRouter (
        .clk            (clk),
        .rst            (rst),
        .resp           (respBus.slave),
        .fetchRespValid (fetchRespValid),
        .fetchRespInst  (fetchRespInst),
        .dataRespValid  (dataRespValid),
        .dataRespData   (dataRespData)
    );

endmodule

/* sim/tbClock.sv */
`timescale 1ns/100ps

module tbClock (
    output logic clk,
    output logic rst
);
    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // reset held over the first 8 rising edges
    initial begin
        rst = 1'b1;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
    end
endmodule

/* sim/memCtrlTb.sv */
`timescale 1ns/100ps
`include "memCtrl_cfg.svh"

module memCtrlTb;
    localparam int NUM_BURST   = 40;
    localparam int NUM_MIX     = 60;
    // directed tests move 44 bytes and each random request counts as 4
    localparam int TOTAL_BYTES = 44 + 4 * 2 * (NUM_BURST + NUM_MIX);
    localparam int CYCLE_LIMIT = 8 * TOTAL_BYTES + 200;

    logic                   clk;
    logic                   rst;
    logic                   ioFull;
    logic                   fetchValid;
    logic                   fetchReady;
    logic [`MEM_ADDR_W-1:0] fetchAddr;
    logic                   fetchRespValid;
    memCtrlPkg::memWord     fetchRespInst;
    logic                   dataValid;
    logic                   dataReady;
    logic                   dataWrite;
    memCtrlPkg::accessLen   dataLen;
    logic [`MEM_ADDR_W-1:0] dataAddr;
    memCtrlPkg::memWord     dataWdata;
    logic                   dataRespValid;
    memCtrlPkg::memWord     dataRespData;

    logic [7:0]             refMem [logic [`MEM_ADDR_W-1:0]];
    memCtrlPkg::memWord     fetchExp [$];
    memCtrlPkg::memWord     dataExp [$];
    string                  fetchNames [$];
    string                  dataNames [$];
    memCtrlPkg::reqSource   orderQ [$];
    string                  fetchName;
    string                  dataName;
    integer                 seed;
    logic                   stallEnable;
    int                     cycles = 0;
    int                     accepted = 0;
    int                     responded = 0;
    int                     maxInFlight = 0;

    tbClock i_tbClock (.*);
    memCtrlTop i_memCtrlTop (.*);

    // little-endian byte-array model with loads zero-extended by length
    function automatic memCtrlPkg::memWord refAccess(
        input logic                   write,
        input memCtrlPkg::accessLen   len,
        input logic [`MEM_ADDR_W-1:0] addr,
        input memCtrlPkg::memWord     wdata
    );
        memCtrlPkg::memWord     word;
        logic [`MEM_ADDR_W-1:0] a;
        word = '0;
        for (int i = 0; i < len; i++) begin
            a = addr + (`MEM_ADDR_W)'(i);
            if (write) begin
                refMem[a] = wdata[8*i +: 8];
            end else if (refMem.exists(a)) begin
                word[8*i +: 8] = refMem[a];
            end
        end
        return word;
    endfunction

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic checkFetch(input string name, input memCtrlPkg::memWord expected,
                              input memCtrlPkg::memWord actual);
        if (actual !== expected) begin
            failRun($sformatf("Mismatch %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    task automatic checkData(input string name, input memCtrlPkg::memWord expected,
                             input memCtrlPkg::memWord actual);
        if (actual !== expected) begin
            failRun($sformatf("Mismatch %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    task automatic checkSource(input string name, input memCtrlPkg::reqSource expected,
                               input memCtrlPkg::reqSource actual);
        if (actual !== expected) begin
            failRun($sformatf("Mismatch %s order: expected port %0d, actual port %0d",
                              name, expected, actual));
        end
    endtask

    task automatic checkInt(input string name, input int expected, input int actual);
        if (actual != expected) begin
            failRun($sformatf("Mismatch %s: expected %0d, actual %0d", name, expected, actual));
        end
    endtask

    // called just after a rising edge and returns just after the transfer edge
    task automatic sendData(input string name, input logic write, input memCtrlPkg::accessLen len,
                            input logic [`MEM_ADDR_W-1:0] addr, input memCtrlPkg::memWord wdata);
        dataName  <= name;
        dataValid <= 1'b1;
        dataWrite <= write;
        dataLen   <= len;
        dataAddr  <= addr;
        dataWdata <= wdata;
        do begin
            @(posedge clk);
        end while (!dataReady);
        dataValid <= 1'b0;
    endtask

    task automatic sendFetch(input string name, input logic [`MEM_ADDR_W-1:0] addr);
        fetchName  <= name;
        fetchValid <= 1'b1;
        fetchAddr  <= addr;
        do begin
            @(posedge clk);
        end while (!fetchReady);
        fetchValid <= 1'b0;
    endtask

    task automatic drain();
        do begin
            @(posedge clk);
        end while (orderQ.size() != 0 || dataValid || fetchValid);
        repeat (2) @(posedge clk);
    endtask

    // waits for an idle pipeline and counts edges from the transfer to the response pulse
    task automatic timedData(input string name, input logic write, input memCtrlPkg::accessLen len,
                             input logic [`MEM_ADDR_W-1:0] addr, input memCtrlPkg::memWord wdata);
        int reqEdge;
        int expLat;
        drain();
        sendData(name, write, len, addr, wdata);
        reqEdge = cycles;
        do begin
            @(posedge clk);
        end while (!dataRespValid);
        // reads pay one extra cycle of RAM latency
        expLat = write ? len + 1 : len + 2;
        // the pulse was launched one edge before the edge that sampled it
        checkInt({name, " latency"}, expLat, cycles - reqEdge - 1);
    endtask

    task automatic randomMix(input string name, input int count, input bit gaps, input bit isData);
        logic                   write;
        memCtrlPkg::accessLen   len;
        logic [`MEM_ADDR_W-1:0] addr;
        for (int i = 0; i < count; i++) begin
            write = $random(seed) & 1;
            case ($random(seed) & 3)
                0:       len = memCtrlPkg::lenByte;
                1:       len = memCtrlPkg::lenHalf;
                default: len = memCtrlPkg::lenWord;
            endcase
            // small window so loads and fetches hit stored bytes
            addr = 'h100 + ($random(seed) & 'h3f);
            if (isData) begin
                sendData(name, write, len, addr, $random(seed));
            end else begin
                sendFetch(name, addr);
            end
            if (gaps && (($random(seed) & 3) == 0)) begin
                @(posedge clk);
            end
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (accepted - responded > maxInFlight) begin
            maxInFlight <= accepted - responded;
        end
        if (cycles >= CYCLE_LIMIT) begin
            failRun($sformatf("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT));
        end
    end

    always @(posedge clk) begin
        if (stallEnable) begin
            ioFull <= (($random(seed) & 3) == 0);
        end else begin
            ioFull <= 1'b0;
        end
    end

    // acceptance monitor feeds the model in transfer order
    always @(posedge clk) begin
        if (!rst) begin
            if (dataValid && fetchReady) begin
                failRun("fetchReady was high while a data request was waiting");
            end
            if (dataValid && dataReady) begin
                dataExp.push_back(refAccess(dataWrite, dataLen, dataAddr, dataWdata));
                dataNames.push_back(dataName);
                orderQ.push_back(memCtrlPkg::dataPort);
                accepted <= accepted + 1;
            end
            if (fetchValid && fetchReady) begin
                fetchExp.push_back(refAccess(1'b0, memCtrlPkg::lenWord, fetchAddr, '0));
                fetchNames.push_back(fetchName);
                orderQ.push_back(memCtrlPkg::fetchPort);
                accepted <= accepted + 1;
            end
        end
    end

    always @(posedge clk) begin
        if (!rst && fetchRespValid) begin
            if (fetchExp.size() == 0) begin
                failRun("fetch response pulse arrived with no fetch outstanding");
            end else begin
                checkSource(fetchNames[0], orderQ.pop_front(), memCtrlPkg::fetchPort);
                checkFetch(fetchNames.pop_front(), fetchExp.pop_front(), fetchRespInst);
                responded <= responded + 1;
            end
        end
        if (!rst && dataRespValid) begin
            if (dataExp.size() == 0) begin
                failRun("data response pulse arrived with no data access outstanding");
            end else begin
                checkSource(dataNames[0], orderQ.pop_front(), memCtrlPkg::dataPort);
                checkData(dataNames.pop_front(), dataExp.pop_front(), dataRespData);
                responded <= responded + 1;
            end
        end
    end

    initial begin
        seed        = 66;
        stallEnable = 1'b0;
        ioFull      = 1'b0;
        fetchValid  = 1'b0;
        fetchAddr   = '0;
        dataValid   = 1'b0;
        dataWrite   = 1'b0;
        dataLen     = memCtrlPkg::lenWord;
        dataAddr    = '0;
        dataWdata   = '0;
        wait (rst === 1'b0);
        @(posedge clk);

        sendData("store byte", 1'b1, memCtrlPkg::lenByte, 'h0010, 32'h1122_33a5);
        sendData("store half", 1'b1, memCtrlPkg::lenHalf, 'h0020, 32'h5566_c3b7);
        sendData("store word", 1'b1, memCtrlPkg::lenWord, 'h0030, 32'h8899_aabb);
        sendData("load byte", 1'b0, memCtrlPkg::lenByte, 'h0010, '0);
        sendData("load half", 1'b0, memCtrlPkg::lenHalf, 'h0020, '0);
        sendData("load word", 1'b0, memCtrlPkg::lenWord, 'h0030, '0);
        sendData("load low byte of word", 1'b0, memCtrlPkg::lenByte, 'h0030, '0);

        sendFetch("fetch stored word", 'h0030);
        sendFetch("fetch over half", 'h0020);
        sendFetch("fetch unwritten", 'h8000);
        sendFetch("fetch unwritten high", 'hff00);

        drain();
        fork
            sendData("priority load", 1'b0, memCtrlPkg::lenWord, 'h0030, '0);
            sendFetch("priority fetch", 'h0010);
        join

        timedData("timed word load", 1'b0, memCtrlPkg::lenWord, 'h0030, '0);
        timedData("timed byte store", 1'b1, memCtrlPkg::lenByte, 'h0040, 32'h0000_005a);

        drain();
        fork
            randomMix("burst data", NUM_BURST, 1'b0, 1'b1);
            randomMix("burst fetch", NUM_BURST, 1'b0, 1'b0);
        join
        drain();
        if (maxInFlight < 2) begin
            failRun("back-to-back requests never had two requests in flight");
        end

        stallEnable <= 1'b1;
        fork
            randomMix("stalled data", NUM_MIX, 1'b1, 1'b1);
            randomMix("stalled fetch", NUM_MIX, 1'b1, 1'b0);
        join
        drain();
        stallEnable <= 1'b0;

        if (responded != accepted) begin
            failRun($sformatf("Mismatch response count: expected %0d, actual %0d",
                              accepted, responded));
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end
endmodule

/* tb.f */
+incdir+hw
hw/memCtrlPkg.sv
hw/memReqIf.sv
hw/memRespIf.sv
hw/memArbiter.sv
hw/byteSequencer.sv
hw/respRouter.sv
hw/byteRam.sv
hw/memCtrlTop.sv
sim/tbClock.sv
sim/memCtrlTb.sv

/* Bender.yml */
package:
  name: memCtrl

sources:
  - include_dirs:
      - hw
    files:
      - hw/memCtrlPkg.sv
      - hw/memReqIf.sv
      - hw/memRespIf.sv
      - hw/memArbiter.sv
      - hw/byteSequencer.sv
      - hw/respRouter.sv
      - hw/byteRam.sv
      - hw/memCtrlTop.sv
  - target: simulation
    files:
      - sim/tbClock.sv
      - sim/memCtrlTb.sv
